// File: bpb_pkg.sv
package bpb_pkg;

    // buffer geometry. Index bits sit just above the word offset of the pc.
    localparam int BPB_ENTRY_WIDTH = 4;
    localparam int BPB_ENTRIES     = 1 << BPB_ENTRY_WIDTH;       // 16 lines, direct mapped.
    localparam int BPB_TAG_WIDTH   = 32 - 2 - BPB_ENTRY_WIDTH;   // upper pc bits, 26 here.

    // fetch width of the dual-issue front end.
    localparam int BPB_SLOTS = 2;

    // a 32-bit address or data word.
    typedef logic [31:0] word_t;

    // direction and target of one branch.
    // the same layout carries a slot prediction and a commit resolution.
    typedef struct packed
    {
        logic  taken;
        word_t destpc;
    } bpb_result_t;

endpackage

// File: bpb_commit_if.sv
interface bpb_commit_if import bpb_pkg::*; ();

    word_t       pc;       // pc of the resolved branch.
    logic        wen;      // level valued, one resolution per cycle.
    bpb_result_t result;   // resolved direction and target.
    logic        stall;    // freezes every line while high.

    // the commit stage side.
    modport source
    (
        output pc,
        output wen,
        output result,
        output stall
    );

    // the buffer side.
    modport sink
    (
        input pc,
        input wen,
        input result,
        input stall
    );

endinterface

// File: bpb_predict_if.sv
interface bpb_predict_if import bpb_pkg::*; ();

    // one entry per fetch slot. Slot 0 is the fetch address itself.
    word_t                pc [BPB_SLOTS];
    logic [BPB_SLOTS-1:0] hit;
    bpb_result_t          result [BPB_SLOTS];

    // the next-address logic asks for the slot addresses.
    modport requester
    (
        output pc,
        input  hit,
        input  result
    );

    // the bank answers with a hit and a prediction for each slot.
    // the answer is purely combinational.
    modport responder
    (
        input  pc,
        output hit,
        output result
    );

endinterface

// File: bpb_line.sv
module bpb_line import bpb_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wen,
    input  word_t                commit_pc,
    input  bpb_result_t          commit_result,
    input  word_t                slot_pc [BPB_SLOTS],
    output logic [BPB_SLOTS-1:0] slot_hit,
    output bpb_result_t          slot_result [BPB_SLOTS]
);

    logic                     valid;
    logic [BPB_TAG_WIDTH-1:0] tag;
    word_t                    target;
    logic [1:0]               state;       // bit 1 set means predict taken.
    logic [1:0]               state_next;
    logic [BPB_TAG_WIDTH-1:0] commit_tag;
    logic                     tag_match;

    assign commit_tag = commit_pc[31 -: BPB_TAG_WIDTH];
    assign tag_match  = valid && (tag == commit_tag);

    // saturating counter with a shortcut from weak taken back to strong not taken.
    always_comb
    begin
        case (state)
            2'b00:   state_next = commit_result.taken ? 2'b01 : 2'b00;
            2'b01:   state_next = commit_result.taken ? 2'b11 : 2'b00;
            2'b10:   state_next = commit_result.taken ? 2'b11 : 2'b00;
            default: state_next = commit_result.taken ? 2'b11 : 2'b10;
        endcase
    end

    // reset empties the line by clearing its valid bit.
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            valid <= 1'b0;
        else if (wen)
            valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            if (!tag_match)
            begin
                // a new branch takes over the line.
                tag    <= commit_tag;
                target <= commit_result.destpc;
                state  <= 2'b00;
            end
            else
                state <= state_next;   // the target is kept on a match.
        end
    end

    // both slots look at the same line when they share an index.
    // the bank picks whichever applies.
    for (genvar s = 0; s < BPB_SLOTS; s++)
    begin : g_slot
        assign slot_hit[s]           = valid && (tag == slot_pc[s][31 -: BPB_TAG_WIDTH]);
        assign slot_result[s].taken  = slot_hit[s] && state[1];
        assign slot_result[s].destpc = target;
    end

endmodule

// File: bpb_bank.sv
module bpb_bank import bpb_pkg::*;
(
    input logic              clk,
    input logic              reset,
    bpb_commit_if.sink       commit,
    bpb_predict_if.responder predict
);

    logic [BPB_ENTRY_WIDTH-1:0] commit_index;
    logic                       commit_accept;
    logic [BPB_ENTRIES-1:0]     line_wen;
    logic [BPB_ENTRY_WIDTH-1:0] slot_index [BPB_SLOTS];

    // per-line answers before the index selection.
    logic [BPB_SLOTS-1:0] line_hit    [BPB_ENTRIES];
    bpb_result_t          line_result [BPB_ENTRIES][BPB_SLOTS];

    assign commit_index  = commit.pc[2 +: BPB_ENTRY_WIDTH];
    assign commit_accept = commit.wen && !commit.stall;   // stall holds every line.

    // one-hot line enable from the commit index.
    always_comb
    begin
        for (int i = 0; i < BPB_ENTRIES; i++)
            line_wen[i] = commit_accept && (commit_index == BPB_ENTRY_WIDTH'(i));
    end

    for (genvar i = 0; i < BPB_ENTRIES; i++)
    begin : g_line
        bpb_line line_i
        (
            .clk           (clk),
            .reset         (reset),
            .wen           (line_wen[i]),
            .commit_pc     (commit.pc),
            .commit_result (commit.result),
            .slot_pc       (predict.pc),
            .slot_hit      (line_hit[i]),
            .slot_result   (line_result[i])
        );
    end

    // each slot reads the line at its own index.
    // with an aligned fetch the two slots land on neighbouring lines.
    always_comb
    begin
        for (int s = 0; s < BPB_SLOTS; s++)
        begin
            slot_index[s]     = predict.pc[s][2 +: BPB_ENTRY_WIDTH];
            predict.hit[s]    = line_hit[slot_index[s]][s];
            predict.result[s] = line_result[slot_index[s]][s];
        end
    end

endmodule

// File: bpb_next_pc.sv
module bpb_next_pc import bpb_pkg::*;
(
    input  word_t                fetch_pc,
    bpb_predict_if.requester     predict,
    output logic [BPB_SLOTS-1:0] hit,
    output logic [BPB_SLOTS-1:0] taken,
    output word_t                next_pc
);

    word_t seq_pc;

    // fetch_pc is 8-byte aligned, so the slots are the two words of one block.
    always_comb
    begin
        for (int s = 0; s < BPB_SLOTS; s++)
            predict.pc[s] = fetch_pc + word_t'(4 * s);
    end

    assign seq_pc = fetch_pc + word_t'(4 * BPB_SLOTS);   // fall through past the block.

    assign hit = predict.hit;

    always_comb
    begin
        for (int s = 0; s < BPB_SLOTS; s++)
            taken[s] = predict.result[s].taken;
    end

    // the earliest taken slot redirects the fetch.
    // counting down leaves the lowest taken slot in place.
    always_comb
    begin
        next_pc = seq_pc;
        for (int s = BPB_SLOTS - 1; s >= 0; s--)
        begin
            if (taken[s])
                next_pc = predict.result[s].destpc;
        end
    end

endmodule

// File: bpb_top.sv
module bpb_top import bpb_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  word_t                fetch_pc,
    output logic [BPB_SLOTS-1:0] hit,
    output logic [BPB_SLOTS-1:0] taken,
    output word_t                next_pc,
    input  word_t                commit_pc,
    input  logic                 commit_wen,
    input  logic                 commit_taken,
    input  word_t                commit_destpc
);

    bpb_commit_if  commit_bus ();
    bpb_predict_if predict_bus ();

    // commit stage ports onto the commit bundle.
    assign commit_bus.pc            = commit_pc;
    assign commit_bus.wen           = commit_wen;
    assign commit_bus.stall         = stall;
    assign commit_bus.result.taken  = commit_taken;
    assign commit_bus.result.destpc = commit_destpc;

    bpb_bank bank_i
    (
        .clk     (clk),
        .reset   (reset),
        .commit  (commit_bus.sink),
        .predict (predict_bus.responder)
    );

    // prediction path has no register anywhere.
    bpb_next_pc next_pc_i
    (
        .fetch_pc (fetch_pc),
        .predict  (predict_bus.requester),
        .hit      (hit),
        .taken    (taken),
        .next_pc  (next_pc)
    );

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20;   // 40 ns clock period.
    localparam int RESET_CYCLES = 5;

    initial
    begin
        clk = 1'b0;
        forever
            #(HALF_PERIOD) clk = ~clk;
    end

    // reset is held over the first rising edges and released just after one of them.
    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES)
            @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: bpb_tb.sv
module bpb_tb import bpb_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES   = 5;    // matches the clock generator.
    localparam int TIMEOUT_MARGIN = 20;
    localparam int DRIVE_DELAY    = 2;    // inputs change this long after a rising edge.
    localparam int SAMPLE_DELAY   = 37;   // outputs are sampled 1 ns before the next edge.

    // one cycle of stimulus with the prediction expected in that cycle.
    typedef struct packed
    {
        logic                 stall;
        logic                 wen;
        word_t                commit_pc;
        logic                 commit_taken;
        word_t                commit_destpc;
        word_t                fetch_pc;
        logic [BPB_SLOTS-1:0] exp_hit;
        logic [BPB_SLOTS-1:0] exp_taken;
        word_t                exp_next;
    } row_t;

    logic                 clk;
    logic                 reset;
    logic                 stall;
    word_t                fetch_pc;
    logic [BPB_SLOTS-1:0] hit;
    logic [BPB_SLOTS-1:0] taken;
    word_t                next_pc;
    word_t                commit_pc;
    logic                 commit_wen;
    logic                 commit_taken;
    word_t                commit_destpc;

    row_t rows [$];
    int   cycle_count;
    int   cycle_limit;

    tb_clock_gen clock_gen_i
    (
        .clk   (clk),
        .reset (reset)
    );

    bpb_top bpb_top_i
    (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .fetch_pc      (fetch_pc),
        .hit           (hit),
        .taken         (taken),
        .next_pc       (next_pc),
        .commit_pc     (commit_pc),
        .commit_wen    (commit_wen),
        .commit_taken  (commit_taken),
        .commit_destpc (commit_destpc)
    );

    task automatic stop_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_hit(input int row, input logic [BPB_SLOTS-1:0] expected,
                             input logic [BPB_SLOTS-1:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL at %0d ns: row %0d hit expected %b got %b",
                     $time, row, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_taken(input int row, input logic [BPB_SLOTS-1:0] expected,
                               input logic [BPB_SLOTS-1:0] actual);
        if (actual !== expected)
        begin
            $display("FAIL at %0d ns: row %0d taken expected %b got %b",
                     $time, row, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_pc(input int row, input word_t expected, input word_t actual);
        if (actual !== expected)
        begin
            $display("FAIL at %0d ns: row %0d next_pc expected %h got %h",
                     $time, row, expected, actual);
            stop_run();
        end
    endtask

    task automatic add_row(input logic stall_in, input logic wen_in, input word_t cpc,
                           input logic ctaken, input word_t cdest, input word_t fpc,
                           input logic [BPB_SLOTS-1:0] ehit,
                           input logic [BPB_SLOTS-1:0] etaken, input word_t enext);
        row_t r;
        r = '{stall_in, wen_in, cpc, ctaken, cdest, fpc, ehit, etaken, enext};
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        stall         = r.stall;
        commit_wen    = r.wen;
        commit_pc     = r.commit_pc;
        commit_taken  = r.commit_taken;
        commit_destpc = r.commit_destpc;
        fetch_pc      = r.fetch_pc;
    endtask

    // the expected columns describe the state left by the edges before the row.
    // a commit in a row only shows up from the next row on.
    task automatic build_table();
        // an empty buffer misses everywhere.
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001000, 2'b00, 2'b00, 32'h00001008);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00002040, 2'b00, 2'b00, 32'h00002048);
        // allocate line 0 and walk its counter up, down and up again.
        add_row(1'b0, 1'b1, 32'h00001000, 1'b1, 32'h00002000,
                32'h00001000, 2'b00, 2'b00, 32'h00001008);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001000, 2'b01, 2'b00, 32'h00001008);
        add_row(1'b0, 1'b1, 32'h00001000, 1'b1, 32'h00002000,
                32'h00001000, 2'b01, 2'b00, 32'h00001008);
        add_row(1'b0, 1'b1, 32'h00001000, 1'b1, 32'h00002000,
                32'h00001000, 2'b01, 2'b00, 32'h00001008);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001000, 2'b01, 2'b01, 32'h00002000);
        add_row(1'b0, 1'b1, 32'h00001000, 1'b0, 32'h00003330,
                32'h00001000, 2'b01, 2'b01, 32'h00002000);
        add_row(1'b0, 1'b1, 32'h00001000, 1'b0, 32'h00003330,
                32'h00001000, 2'b01, 2'b01, 32'h00002000);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001000, 2'b01, 2'b00, 32'h00001008);
        add_row(1'b0, 1'b1, 32'h00001000, 1'b1, 32'h00003330,
                32'h00001000, 2'b01, 2'b00, 32'h00001008);
        add_row(1'b0, 1'b1, 32'h00001000, 1'b1, 32'h00003330,
                32'h00001000, 2'b01, 2'b00, 32'h00001008);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001000, 2'b01, 2'b01, 32'h00002000);   // target kept on a match.
        // a new tag at index 0 takes the line over.
        add_row(1'b0, 1'b1, 32'h00001040, 1'b1, 32'h00004000,
                32'h00001000, 2'b01, 2'b01, 32'h00002000);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001000, 2'b00, 2'b00, 32'h00001008);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001040, 2'b01, 2'b00, 32'h00001048);
        add_row(1'b0, 1'b1, 32'h00001040, 1'b1, 32'h00004000,
                32'h00001040, 2'b01, 2'b00, 32'h00001048);
        add_row(1'b0, 1'b1, 32'h00001040, 1'b1, 32'h00004000,
                32'h00001040, 2'b01, 2'b00, 32'h00001048);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001040, 2'b01, 2'b01, 32'h00004000);
        // commits under stall are dropped.
        add_row(1'b1, 1'b1, 32'h00001040, 1'b0, 32'h00000000,
                32'h00001040, 2'b01, 2'b01, 32'h00004000);
        add_row(1'b1, 1'b1, 32'h00001040, 1'b0, 32'h00000000,
                32'h00001040, 2'b01, 2'b01, 32'h00004000);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001040, 2'b01, 2'b01, 32'h00004000);
        add_row(1'b1, 1'b1, 32'h00001100, 1'b1, 32'h00005500,
                32'h00001100, 2'b00, 2'b00, 32'h00001108);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001100, 2'b00, 2'b00, 32'h00001108);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00001040, 2'b01, 2'b01, 32'h00004000);
        // train lines 2 and 3 so both slots of one fetch block predict taken.
        add_row(1'b0, 1'b1, 32'h00002008, 1'b1, 32'h00005000,
                32'h00002008, 2'b00, 2'b00, 32'h00002010);
        add_row(1'b0, 1'b1, 32'h00002008, 1'b1, 32'h00005000,
                32'h00002008, 2'b01, 2'b00, 32'h00002010);
        add_row(1'b0, 1'b1, 32'h00002008, 1'b1, 32'h00005000,
                32'h00002008, 2'b01, 2'b00, 32'h00002010);
        add_row(1'b0, 1'b1, 32'h0000200c, 1'b1, 32'h00006000,
                32'h00002008, 2'b01, 2'b01, 32'h00005000);
        add_row(1'b0, 1'b1, 32'h0000200c, 1'b1, 32'h00006000,
                32'h00002008, 2'b11, 2'b01, 32'h00005000);
        add_row(1'b0, 1'b1, 32'h0000200c, 1'b1, 32'h00006000,
                32'h00002008, 2'b11, 2'b01, 32'h00005000);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00002008, 2'b11, 2'b11, 32'h00005000);   // slot 0 wins.
        // weaken slot 0 until only slot 1 redirects.
        add_row(1'b0, 1'b1, 32'h00002008, 1'b0, 32'h00000000,
                32'h00002008, 2'b11, 2'b11, 32'h00005000);
        add_row(1'b0, 1'b1, 32'h00002008, 1'b0, 32'h00000000,
                32'h00002008, 2'b11, 2'b11, 32'h00005000);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00002008, 2'b11, 2'b10, 32'h00006000);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00002048, 2'b00, 2'b00, 32'h00002050);
        // replacing line 2 leaves slot 1 as the only hit of the block.
        add_row(1'b0, 1'b1, 32'h00002048, 1'b1, 32'h00007000,
                32'h00002008, 2'b11, 2'b10, 32'h00006000);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00002008, 2'b10, 2'b10, 32'h00006000);
        add_row(1'b0, 1'b0, 32'h00000000, 1'b0, 32'h00000000,
                32'h00002048, 2'b01, 2'b00, 32'h00002050);
    endtask

    // ends a run that stops making progress.
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit)
        begin
            $display("timeout: the stimulus table did not finish within %0d cycles",
                     cycle_limit);
            stop_run();
        end
    end

    initial
    begin
        stall         = 1'b0;
        fetch_pc      = '0;
        commit_pc     = '0;
        commit_wen    = 1'b0;
        commit_taken  = 1'b0;
        commit_destpc = '0;
        cycle_count   = 0;

        build_table();
        cycle_limit = rows.size() + RESET_CYCLES + TIMEOUT_MARGIN;

        @(negedge reset);
        for (int r = 0; r < rows.size(); r++)
        begin
            @(posedge clk);
            #(DRIVE_DELAY);
            drive_row(rows[r]);
            #(SAMPLE_DELAY);   // prediction is combinational and settled here.
            check_hit(r, rows[r].exp_hit, hit);
            check_taken(r, rows[r].exp_taken, taken);
            check_pc(r, rows[r].exp_next, next_pc);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: src.f
bpb_pkg.sv
bpb_commit_if.sv
bpb_predict_if.sv
bpb_line.sv
bpb_bank.sv
bpb_next_pc.sv
bpb_top.sv
tb_clock_gen.sv
bpb_tb.sv

// File: Makefile
# Verilator build and run of the branch prediction buffer testbench.
# The run passes only when the log holds the pass line.

LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f src.f --top-module bpb_tb -Mdir obj_dir -o bpb_sim
	-./obj_dir/bpb_sim > $(LOG) 2>&1
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
